// File: dv/loadStoreQueue_props.sv
module loadStoreQueue_props import lsqPkg::*; (
    input logic       clk,
    input logic       rstn,
    input DispatchReq dispatch,
    input logic       full,
    input MemRequest  memRequest
);

    // the queue silently drops a dispatch when full, so the core has to stall first
    noDispatchWhenFull: assert property (@(posedge clk) disable iff (!rstn)
        dispatch.valid |-> !full)
        else $error("dispatch strobe while the load-store queue is full");

    // no request leaves during reset or in the first cycle after it because no entry is live yet
    idleAfterReset: assert property (@(posedge clk) (!rstn || $rose(rstn)) |=> !memRequest.valid)
        else $error("memory request valid during reset or in the cycle after it");

    fwdIsLoad: assert property (@(posedge clk) disable iff (!rstn)
        memRequest.valid && memRequest.forwarded |-> !memRequest.isStore)
        else $error("forwarded memory request carries a store");  // only loads take forwarded data

endmodule

bind loadStoreQueue loadStoreQueue_props loadStoreQueue_props_inst (
    .clk        (clk),
    .rstn       (rstn),
    .dispatch   (dispatch),
    .full       (full),
    .memRequest (memRequest)
);

// File: dv/memBackEndTb.sv
module memBackEndTb import lsqPkg::*; ();

    localparam int queueDepth = 16;
    localparam int memWords   = 256;
    localparam int wordBits   = $clog2(memWords);
    localparam int cycleLimit = 2000;  // far more than all tests need together
    localparam int waitLimit  = 40;    // longest wait for a single completion

    logic         clk;
    logic         rstn;
    DispatchReq   dispatch;
    AddressUpdate addrUpdate;
    RetireReq     retire;
    MemCompletion completion;
    logic         full;

    MemWord       refMem [memWords];  // model memory that a store updates once it completes
    MemCompletion seenQ[$];           // completions in the order they arrived
    int           seenCycle[$];       // cycle count of each completion
    int           lastCycle;
    int           cycles = 0;
    int           valueErrors;
    int           otherErrors;

    memBackEnd #(
        .queueDepth (queueDepth),
        .memWords   (memWords)
    ) memBackEnd_inst (
        .clk        (clk),
        .rstn       (rstn),
        .dispatch   (dispatch),
        .addrUpdate (addrUpdate),
        .retire     (retire),
        .completion (completion),
        .full       (full)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // counts rising edges and stops a run that hangs
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("test failed");
            $finish;
        end
    end

    // completion is registered on the rising edge so the falling edge sees it settled
    always @(negedge clk) begin
        if (rstn && completion.valid) begin
            seenQ.push_back(completion);
            seenCycle.push_back(cycles);
        end
    end

    // one rising edge passes, then every strobe drops again
    task automatic step();
        @(posedge clk);
        #2;
        dispatch.valid   = 1'b0;
        addrUpdate.valid = 1'b0;
        retire.valid0    = 1'b0;
        retire.valid1    = 1'b0;
    endtask

    task automatic sendDispatch(input logic [31:0] pc, input logic isStore, input logic isByte,
                                input logic [31:0] data);
        dispatch.valid     = 1'b1;
        dispatch.pc        = pc;
        dispatch.isStore   = isStore;
        dispatch.isByte    = isByte;
        dispatch.storeData = data;
        step();
    endtask

    task automatic sendAddress(input logic [31:0] pc, input logic [31:0] address);
        addrUpdate.valid   = 1'b1;
        addrUpdate.pc      = pc;
        addrUpdate.address = address;
        step();
    endtask

    task automatic sendRetire(input logic [31:0] pc0, input logic valid1, input logic [31:0] pc1);
        retire.valid0 = 1'b1;
        retire.pc0    = pc0;
        retire.valid1 = valid1;  // second slot is optional
        retire.pc1    = pc1;
        step();
    endtask

    // a store lands in one lane or in the whole word of the model
    task automatic modelStore(input logic [31:0] address, input logic isByte,
                              input logic [31:0] data);
        MemWord w;
        w = refMem[address[wordBits+1:2]];
        if (isByte) begin
            w.bytes[address[1:0]] = data[7:0];
        end else begin
            w.word = data;
        end
        refMem[address[wordBits+1:2]] = w;
    endtask

    function automatic logic [31:0] modelLoad(input logic [31:0] address, input logic isByte);
        MemWord w;
        w = refMem[address[wordBits+1:2]];
        if (isByte) begin
            return {24'b0, w.bytes[address[1:0]]};  // zero-extended byte
        end
        return w.word;
    endfunction

    function automatic MemCompletion makeCompletion(input logic [31:0] pc, input logic isStore,
                                                    input logic [31:0] data,
                                                    input logic forwarded);
        MemCompletion c;
        c.valid     = 1'b1;
        c.pc        = pc;
        c.isStore   = isStore;
        c.data      = data;
        c.forwarded = forwarded;
        return c;
    endfunction

    task automatic checkCompletion(input string name, input MemCompletion exp,
                                   input MemCompletion act);
        if (act.pc !== exp.pc || act.isStore !== exp.isStore || act.data !== exp.data ||
            act.forwarded !== exp.forwarded) begin
            $write("[FAIL] %s expected pc %h store %b data %h fwd %b", name, exp.pc,
                   exp.isStore, exp.data, exp.forwarded);
            $display(" actual pc %h store %b data %h fwd %b", act.pc,
                     act.isStore, act.data, act.forwarded);
            valueErrors++;
        end
    endtask

    task automatic checkFull(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s full expected %b actual %b", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkCycles(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s cycles expected %0d actual %0d", name, exp, act);
            valueErrors++;
        end
    endtask

    // waits for the next completion and compares it
    task automatic expectCompletion(input string name, input MemCompletion exp);
        int waited;
        waited = 0;
        while (seenQ.size() == 0 && waited < waitLimit) begin
            step();
            waited++;
        end
        if (seenQ.size() == 0) begin
            $display("%s got no completion for pc %h within %0d cycles", name, exp.pc, waitLimit);
            otherErrors++;
        end else begin
            lastCycle = seenCycle.pop_front();  // arrival cycle kept for latency checks
            checkCompletion(name, exp, seenQ.pop_front());
        end
    endtask

    task automatic testForwarding();
        logic [31:0] data;
        int          addrCycle;
        data = $urandom;
        sendDispatch(32'h100, 1'b1, 1'b0, data);
        sendDispatch(32'h104, 1'b0, 1'b0, 32'h0);
        sendAddress(32'h100, 32'h40);
        sendAddress(32'h104, 32'h40);
        addrCycle = cycles;  // edge where the load address was taken
        expectCompletion("forwarding", makeCompletion(32'h100, 1'b1, 32'h0, 1'b0));
        modelStore(32'h40, 1'b0, data);
        expectCompletion("forwarding", makeCompletion(32'h104, 1'b0, data, 1'b1));
        checkCycles("forwarding latency", 2, lastCycle - addrCycle);
        sendRetire(32'h100, 1'b1, 32'h104);
    endtask

    task automatic testMemoryPath();
        logic [31:0] data;
        data = $urandom;
        sendDispatch(32'h200, 1'b1, 1'b0, data);
        sendAddress(32'h200, 32'h80);
        expectCompletion("memory path", makeCompletion(32'h200, 1'b1, 32'h0, 1'b0));
        modelStore(32'h80, 1'b0, data);
        sendRetire(32'h200, 1'b0, 32'h0);  // store is gone so the load must read memory
        sendDispatch(32'h204, 1'b0, 1'b0, 32'h0);
        sendAddress(32'h204, 32'h80);
        expectCompletion("memory path",
                         makeCompletion(32'h204, 1'b0, modelLoad(32'h80, 1'b0), 1'b0));
        sendRetire(32'h204, 1'b0, 32'h0);
    endtask

    task automatic testByteLanes();
        logic [31:0] data;
        data = $urandom;
        sendDispatch(32'h300, 1'b1, 1'b1, data);
        sendAddress(32'h300, 32'h81);  // lane 1 of the word written before
        expectCompletion("byte lanes", makeCompletion(32'h300, 1'b1, 32'h0, 1'b0));
        modelStore(32'h81, 1'b1, data);
        sendRetire(32'h300, 1'b0, 32'h0);
        sendDispatch(32'h304, 1'b0, 1'b0, 32'h0);
        sendDispatch(32'h308, 1'b0, 1'b1, 32'h0);
        sendAddress(32'h304, 32'h80);
        sendAddress(32'h308, 32'h81);
        expectCompletion("byte lanes",
                         makeCompletion(32'h304, 1'b0, modelLoad(32'h80, 1'b0), 1'b0));
        expectCompletion("byte lanes",
                         makeCompletion(32'h308, 1'b0, modelLoad(32'h81, 1'b1), 1'b0));
        sendRetire(32'h304, 1'b1, 32'h308);
        // a word store then a byte load go through memory since sizes never forward
        data = $urandom;
        sendDispatch(32'h30c, 1'b1, 1'b0, data);
        sendDispatch(32'h310, 1'b0, 1'b1, 32'h0);
        sendAddress(32'h30c, 32'h90);
        sendAddress(32'h310, 32'h92);
        expectCompletion("byte lanes", makeCompletion(32'h30c, 1'b1, 32'h0, 1'b0));
        modelStore(32'h90, 1'b0, data);
        expectCompletion("byte lanes",
                         makeCompletion(32'h310, 1'b0, modelLoad(32'h92, 1'b1), 1'b0));
        sendRetire(32'h30c, 1'b1, 32'h310);
    endtask

    task automatic testProgramOrder();
        logic [31:0] data;
        data = $urandom;
        sendDispatch(32'h400, 1'b1, 1'b0, data);
        sendDispatch(32'h404, 1'b0, 1'b0, 32'h0);
        sendDispatch(32'h408, 1'b0, 1'b1, 32'h0);
        sendAddress(32'h404, 32'ha0);  // younger two first
        sendAddress(32'h408, 32'ha3);
        repeat (5) step();
        if (seenQ.size() != 0) begin
            $display("program order: a completion came before the oldest entry had its address");
            otherErrors++;
            seenQ.delete();
            seenCycle.delete();
        end
        sendAddress(32'h400, 32'ha0);
        expectCompletion("program order", makeCompletion(32'h400, 1'b1, 32'h0, 1'b0));
        modelStore(32'ha0, 1'b0, data);
        expectCompletion("program order",
                         makeCompletion(32'h404, 1'b0, modelLoad(32'ha0, 1'b0), 1'b0));
        expectCompletion("program order",
                         makeCompletion(32'h408, 1'b0, modelLoad(32'ha3, 1'b1), 1'b0));
        sendRetire(32'h400, 1'b1, 32'h404);
        sendRetire(32'h408, 1'b0, 32'h0);
    endtask

    task automatic testOccupancy();
        logic [31:0] data [queueDepth];
        for (int i = 0; i < queueDepth; i++) begin
            data[i] = $urandom;
            if (i == queueDepth - 1) begin
                checkFull("occupancy one free", 1'b0, full);
            end
            sendDispatch(32'h500 + 4 * i, 1'b1, 1'b0, data[i]);
        end
        checkFull("occupancy all taken", 1'b1, full);
        for (int i = 0; i < 2; i++) begin
            sendAddress(32'h500 + 4 * i, 32'h200 + 4 * i);
        end
        for (int i = 0; i < 2; i++) begin
            expectCompletion("occupancy", makeCompletion(32'h500 + 4 * i, 1'b1, 32'h0, 1'b0));
            modelStore(32'h200 + 4 * i, 1'b0, data[i]);
        end
        sendRetire(32'h500, 1'b1, 32'h504);
        checkFull("occupancy two retired", 1'b0, full);
        // these reuse the freed slots behind the wrapped tail
        sendDispatch(32'h600, 1'b0, 1'b0, 32'h0);
        sendDispatch(32'h604, 1'b0, 1'b1, 32'h0);
        for (int i = 2; i < queueDepth; i++) begin
            sendAddress(32'h500 + 4 * i, 32'h200 + 4 * i);
        end
        sendAddress(32'h600, 32'h200);
        sendAddress(32'h604, 32'h206);
        for (int i = 2; i < queueDepth; i++) begin
            expectCompletion("occupancy", makeCompletion(32'h500 + 4 * i, 1'b1, 32'h0, 1'b0));
            modelStore(32'h200 + 4 * i, 1'b0, data[i]);
        end
        expectCompletion("occupancy",
                         makeCompletion(32'h600, 1'b0, modelLoad(32'h200, 1'b0), 1'b0));
        expectCompletion("occupancy",
                         makeCompletion(32'h604, 1'b0, modelLoad(32'h206, 1'b1), 1'b0));
        for (int i = 2; i < queueDepth; i += 2) begin
            sendRetire(32'h500 + 4 * i, 1'b1, 32'h504 + 4 * i);
        end
        sendRetire(32'h600, 1'b1, 32'h604);
    endtask

    initial begin
        void'($urandom(32'h7d5e354b));
        rstn        = 1'b0;
        dispatch    = '0;
        addrUpdate  = '0;
        retire      = '0;
        valueErrors = 0;
        otherErrors = 0;
        for (int i = 0; i < memWords; i++) begin
            refMem[i] = '0;  // the DUT clears its memory in reset too
        end
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        testForwarding();
        testMemoryPath();
        testByteLanes();
        testProgramOrder();
        testOccupancy();
        repeat (4) step();
        if (seenQ.size() != 0) begin
            $display("%0d completions arrived that no test asked for", seenQ.size());
            otherErrors++;
        end
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: lsqMem.f
src/lsqPkg.sv
src/loadStoreQueue.sv
src/dataMemory.sv
src/memBackEnd.sv
dv/loadStoreQueue_props.sv
dv/memBackEndTb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module memBackEndTb \
    -f lsqMem.f > build.log 2>&1 &&
    ./obj_dir/VmemBackEndTb > sim.log 2>&1 ||
    { echo "build or simulation stopped with an error, see build.log and sim.log"; exit 1; }
grep -q "test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: src/dataMemory.sv
module dataMemory import lsqPkg::*; #(
    parameter int memWords = 256  // addresses wrap at memWords*4 bytes
) (
    input  logic         clk,
    input  logic         rstn,
    input  MemRequest    memRequest,
    output MemCompletion completion
);

    localparam int wordBits = $clog2(memWords);

    MemWord memArray [memWords];

    logic [wordBits-1:0] wordIdx;
    logic [1:0]          laneIdx;
    MemWord              readWord;
    MemWord              writeWord;
    logic [31:0]         loadData;

    assign wordIdx  = memRequest.address[wordBits+1:2];  // the upper bits are dropped so it wraps
    assign laneIdx  = memRequest.address[1:0];
    assign readWord = memArray[wordIdx];

    // a byte store merges into the current word, only its own lane changes
    always_comb begin
        writeWord = readWord;
        if (memRequest.isByte) begin
            writeWord.bytes[laneIdx] = memRequest.data[7:0];
        end else begin
            writeWord.word = memRequest.data;
        end
    end

    assign loadData = memRequest.isByte ? {24'b0, readWord.bytes[laneIdx]} : readWord.word;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            completion.valid <= 1'b0;
            for (int i = 0; i < memWords; i++) begin
                memArray[i] <= '0;
            end
        end else begin
            completion.valid <= memRequest.valid;  // exactly one stage after the request
            if (memRequest.valid) begin
                completion.pc        <= memRequest.pc;
                completion.isStore   <= memRequest.isStore;
                completion.forwarded <= memRequest.forwarded;
                if (memRequest.forwarded) begin
                    completion.data <= memRequest.data;  // array untouched
                end else if (memRequest.isStore) begin
                    memArray[wordIdx] <= writeWord;
                    completion.data   <= '0;
                end else begin
                    completion.data <= loadData;
                end
            end
        end
    end

endmodule

// File: src/loadStoreQueue.sv
module loadStoreQueue import lsqPkg::*; #(
    parameter int queueDepth = 16  // number of entries, a power of two
) (
    input  logic         clk,
    input  logic         rstn,
    input  DispatchReq   dispatch,
    input  AddressUpdate addrUpdate,
    input  RetireReq     retire,
    output MemRequest    memRequest,
    output logic         full
);

    localparam int ptrW = $clog2(queueDepth);

    // control state of every entry, cleared by reset
    logic [queueDepth-1:0] entryValid;
    logic [queueDepth-1:0] issued;
    logic [queueDepth-1:0] addrValid;
    logic [queueDepth-1:0] fwdValid;   // the load already holds its data from an older store
    logic [ptrW-1:0]       head;       // oldest live entry, or tail when the queue is empty
    logic [ptrW-1:0]       tail;       // next slot to allocate

    // payload of every entry
    logic [queueDepth-1:0] isStoreQ;
    logic [queueDepth-1:0] isByteQ;
    logic [31:0]           pcQ   [queueDepth];
    logic [31:0]           addrQ [queueDepth];
    logic [31:0]           dataQ [queueDepth];  // store data, or forwarded data for a load

    logic            dispatchGo;
    logic [queueDepth-1:0] retireHit;
    logic [ptrW-1:0] entryAge [queueDepth];
    logic [ptrW-1:0] nextHead;
    logic            capFound;
    logic [ptrW-1:0] capIdx;
    logic            capWordLoad;
    logic            fwdFound;
    logic [31:0]     fwdData;
    logic [ptrW-1:0] fwdAge;
    logic            issueGo;
    logic [ptrW-1:0] issueIdx;

    // allocation always goes to the tail, so the queue is full once that slot is taken
    assign full       = entryValid[tail];
    assign dispatchGo = dispatch.valid && !full;

    // age is the distance from the head and wraps with the pointer width
    always_comb begin
        for (int i = 0; i < queueDepth; i++) begin
            entryAge[i] = ptrW'(i) - head;
        end
    end

    always_comb begin
        for (int i = 0; i < queueDepth; i++) begin
            retireHit[i] = entryValid[i] &&
                           ((retire.valid0 && retire.pc0 == pcQ[i]) ||
                            (retire.valid1 && retire.pc1 == pcQ[i]));
        end
    end

    // the head jumps to the oldest entry that survives this cycle's retirement
    always_comb begin
        logic            headFound;
        logic [ptrW-1:0] idx;
        headFound = 1'b0;
        nextHead  = tail;  // nothing left behind, so the queue restarts at the tail
        for (int k = 0; k < queueDepth; k++) begin
            idx = head + ptrW'(k);
            if (!headFound && entryValid[idx] && !retireHit[idx]) begin
                headFound = 1'b1;
                nextHead  = idx;
            end
        end
    end

    // find the entry that waits for this address
    always_comb begin
        capFound = 1'b0;
        capIdx   = '0;
        for (int i = 0; i < queueDepth; i++) begin
            if (!capFound && addrUpdate.valid && entryValid[i] && !addrValid[i] &&
                pcQ[i] == addrUpdate.pc) begin
                capFound = 1'b1;
                capIdx   = ptrW'(i);
            end
        end
    end

    assign capWordLoad = capFound && !isStoreQ[capIdx] && !isByteQ[capIdx];

    // forwarding picks the youngest older word store with the same known address
    always_comb begin
        fwdFound = 1'b0;
        fwdData  = '0;
        fwdAge   = '0;
        for (int j = 0; j < queueDepth; j++) begin
            if (capWordLoad && entryValid[j] && isStoreQ[j] && !isByteQ[j] && addrValid[j] &&
                addrQ[j] == addrUpdate.address && entryAge[j] < entryAge[capIdx] &&
                (!fwdFound || entryAge[j] > fwdAge)) begin
                fwdFound = 1'b1;
                fwdData  = dataQ[j];
                fwdAge   = entryAge[j];  // a younger match further on replaces this one
            end
        end
    end

    // a forwarded load may go ahead since it never touches memory
    // everything else leaves strictly in program order
    always_comb begin
        logic            fwdPick;
        logic [ptrW-1:0] fwdPickIdx;
        logic            oldPick;
        logic [ptrW-1:0] oldPickIdx;
        logic [ptrW-1:0] idx;
        fwdPick    = 1'b0;
        fwdPickIdx = '0;
        oldPick    = 1'b0;
        oldPickIdx = '0;
        for (int k = 0; k < queueDepth; k++) begin
            idx = head + ptrW'(k);
            if (entryValid[idx] && !issued[idx]) begin
                if (!oldPick) begin
                    oldPick    = 1'b1;
                    oldPickIdx = idx;
                end
                if (!fwdPick && fwdValid[idx]) begin
                    fwdPick    = 1'b1;
                    fwdPickIdx = idx;
                end
            end
        end
        // the oldest entry blocks issue until its address is known
        issueGo  = fwdPick || (oldPick && addrValid[oldPickIdx]);
        issueIdx = fwdPick ? fwdPickIdx : oldPickIdx;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            entryValid <= '0;
            issued     <= '0;
            addrValid  <= '0;
            fwdValid   <= '0;
            head       <= '0;
            tail       <= '0;
        end else begin
            for (int i = 0; i < queueDepth; i++) begin
                if (retireHit[i]) begin
                    entryValid[i] <= 1'b0;
                end
            end
            if (dispatchGo) begin  // the tail slot is free here, so no retire hits it
                entryValid[tail] <= 1'b1;
                issued[tail]     <= 1'b0;
                addrValid[tail]  <= 1'b0;
                fwdValid[tail]   <= 1'b0;
                tail             <= tail + 1'b1;
            end
            if (capFound) begin
                addrValid[capIdx] <= 1'b1;
                fwdValid[capIdx]  <= fwdFound;
            end
            if (issueGo) begin
                issued[issueIdx] <= 1'b1;
            end
            head <= nextHead;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatchGo) begin
            pcQ[tail]      <= dispatch.pc;
            isStoreQ[tail] <= dispatch.isStore;
            isByteQ[tail]  <= dispatch.isByte;
            dataQ[tail]    <= dispatch.storeData;
        end
        if (capFound) begin
            addrQ[capIdx] <= addrUpdate.address;
            if (fwdFound) begin
                dataQ[capIdx] <= fwdData;  // the load now carries its own result
            end
        end
    end

    // one request per cycle, payload only loaded when something issues
    always_ff @(posedge clk) begin
        if (!rstn) begin
            memRequest.valid <= 1'b0;
        end else begin
            memRequest.valid <= issueGo;
            if (issueGo) begin
                memRequest.pc        <= pcQ[issueIdx];
                memRequest.isStore   <= isStoreQ[issueIdx];
                memRequest.isByte    <= isByteQ[issueIdx];
                memRequest.address   <= addrQ[issueIdx];
                memRequest.forwarded <= fwdValid[issueIdx];
                // a plain load has no data of its own yet
                if (isStoreQ[issueIdx] || fwdValid[issueIdx]) begin
                    memRequest.data <= dataQ[issueIdx];
                end else begin
                    memRequest.data <= '0;
                end
            end
        end
    end

endmodule

// File: src/lsqPkg.sv
package lsqPkg;

    // one memory instruction as it leaves dispatch in program order
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        isStore;    // 1 for a store and 0 for a load
        logic        isByte;     // 1 for a byte access and 0 for a word access
        logic [31:0] storeData;  // rs2 value of a store, don't care for a load
    } DispatchReq;

    // computed address from the address unit, matched to its entry by pc
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] address;
    } AddressUpdate;

    // up to two entries leave the queue per cycle
    typedef struct packed {
        logic        valid0;
        logic [31:0] pc0;
        logic        valid1;
        logic [31:0] pc1;
    } RetireReq;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        isStore;
        logic        isByte;
        logic [31:0] address;
        logic [31:0] data;       // store data or the forwarded load value
        logic        forwarded;  // set when the memory array must be skipped
    } MemRequest;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        isStore;
        logic [31:0] data;       // load data and zero for a store
        logic        forwarded;
    } MemCompletion;

    // byte 0 sits in bits 7:0 of the word
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } MemWord;

endpackage

// File: src/memBackEnd.sv
module memBackEnd import lsqPkg::*; #(
    parameter int queueDepth = 16,  // queue entries, a power of two
    parameter int memWords   = 256  // words in the data memory
) (
    input  logic         clk,
    input  logic         rstn,
    input  DispatchReq   dispatch,
    input  AddressUpdate addrUpdate,
    input  RetireReq     retire,
    output MemCompletion completion,
    output logic         full
);

    // registered request from the queue, one per cycle at most
    MemRequest memRequest;

    // holds memory instructions from dispatch to retirement
    loadStoreQueue #(
        .queueDepth (queueDepth)
    ) loadStoreQueue_inst (
        .clk        (clk),
        .rstn       (rstn),
        .dispatch   (dispatch),
        .addrUpdate (addrUpdate),
        .retire     (retire),
        .memRequest (memRequest),
        .full       (full)
    );

    // forwarded loads also pass through here so all results share one stream
    dataMemory #(
        .memWords   (memWords)
    ) dataMemory_inst (
        .clk        (clk),
        .rstn       (rstn),
        .memRequest (memRequest),
        .completion (completion)
    );

endmodule
